// File: hyper_defs.svh
////////////////////////////////////////////////////////////////////////////
// Channel count, bus widths and FIFO depths of the HyperBus engine
////////////////////////////////////////////////////////////////////////////

`ifndef HYPER_DEFS_SVH
`define HYPER_DEFS_SVH

// Command channels
`define HYPER_NB_CH 4

// HyperBus address and transfer length in 32-bit words
`define HYPER_ADDR_W 32
`define HYPER_LEN_W 8

// Queue depths
`define HYPER_CMD_DEPTH 4
`define HYPER_RX_DEPTH 4

`endif

// File: hyper_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Data, beat, channel-id and command types of the HyperBus engine
////////////////////////////////////////////////////////////////////////////

`include "hyper_defs.svh"

package hyper_pkg;

   localparam int CH_W = $clog2(`HYPER_NB_CH);

   // uDMA side word and PHY side beat
   typedef logic [31:0] word_t;
   typedef logic [15:0] beat_t;

   typedef logic [CH_W-1:0] ch_id_t;

   // One queued transfer request
   typedef struct packed {
      logic                    write;
      logic [`HYPER_ADDR_W-1:0] addr;
      logic [`HYPER_LEN_W-1:0]  len;
      ch_id_t                  ch;
   } hyper_cmd_t;

endpackage

// File: hyper_fifo.sv
////////////////////////////////////////////////////////////////////////////
// Synchronous valid/ready FIFO with a type-parameter payload
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "hyper_defs.svh"

module hyper_fifo
   import hyper_pkg::*;
#(
   parameter type T     = word_t,
   parameter int  DEPTH = `HYPER_CMD_DEPTH
)
(
   input  logic sys_clk_i,
   input  logic rst_n_i,
   input  logic push_valid_i,
   input  T     push_data_i,
   output logic push_ready_o,
   output logic pop_valid_o,
   output T     pop_data_o,
   input  logic pop_ready_i
);

   localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CW = $clog2(DEPTH + 1);

   T              mem [DEPTH];
   logic [AW-1:0] wr_ptr_q;
   logic [AW-1:0] rd_ptr_q;
   logic [CW-1:0] count_q;
   logic          push;
   logic          pop;

   function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] ptr);
      return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign push_ready_o = (count_q != CW'(DEPTH));
   assign pop_valid_o  = (count_q != '0);
   assign pop_data_o   = mem[rd_ptr_q];
   assign push         = push_valid_i & push_ready_o;
   assign pop          = pop_valid_o & pop_ready_i;

   always_ff @(posedge sys_clk_i)
   begin
      if (push)
         mem[wr_ptr_q] <= push_data_i;
   end

   always_ff @(posedge sys_clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr_q <= ptr_inc(wr_ptr_q);
         if (pop)
            rd_ptr_q <= ptr_inc(rd_ptr_q);
         // Simultaneous push and pop keeps the fill level
         if (push && !pop)
            count_q <= count_q + 1'b1;
         else if (pop && !push)
            count_q <= count_q - 1'b1;
      end
   end

endmodule

// File: hyper_cmd_arbiter.sv
////////////////////////////////////////////////////////////////////////////
// Round-robin arbiter over the uDMA channel command ports
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "hyper_defs.svh"

module hyper_cmd_arbiter
   import hyper_pkg::*;
(
   input  logic                                      sys_clk_i,
   input  logic                                      rst_n_i,
   input  logic [`HYPER_NB_CH-1:0]                   cmd_valid_i,
   input  logic [`HYPER_NB_CH-1:0]                   cmd_write_i,
   input  logic [`HYPER_NB_CH-1:0][`HYPER_ADDR_W-1:0] cmd_addr_i,
   input  logic [`HYPER_NB_CH-1:0][`HYPER_LEN_W-1:0]  cmd_len_i,
   output logic [`HYPER_NB_CH-1:0]                   cmd_ready_o,
   output logic                                      q_valid_o,
   output hyper_cmd_t                                q_cmd_o,
   input  logic                                      q_ready_i
);

   logic   gnt_found;
   ch_id_t gnt_id;
   ch_id_t rr_ptr_q;

   // Search starts at the pointer and wraps
   always_comb
   begin
      int idx;
      gnt_found = 1'b0;
      gnt_id    = rr_ptr_q;
      for (int i = 0; i < `HYPER_NB_CH; i++)
      begin
         idx = (int'(rr_ptr_q) + i) % `HYPER_NB_CH;
         if (!gnt_found && cmd_valid_i[idx])
         begin
            gnt_found = 1'b1;
            gnt_id    = ch_id_t'(idx);
         end
      end
   end

   always_comb
   begin
      cmd_ready_o = '0;
      if (gnt_found && q_ready_i)
         cmd_ready_o[gnt_id] = 1'b1;
   end

   assign q_valid_o     = gnt_found;
   assign q_cmd_o.write = cmd_write_i[gnt_id];
   assign q_cmd_o.addr  = cmd_addr_i[gnt_id];
   assign q_cmd_o.len   = cmd_len_i[gnt_id];
   assign q_cmd_o.ch    = gnt_id;

   always_ff @(posedge sys_clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
         rr_ptr_q <= '0;
      else if (gnt_found && q_ready_i)
         rr_ptr_q <= (gnt_id == ch_id_t'(`HYPER_NB_CH - 1)) ? '0 : gnt_id + 1'b1;
   end

endmodule

// File: hyper_trans_ctrl.sv
////////////////////////////////////////////////////////////////////////////
// Transaction controller, one PHY transaction at a time
// Counts data beats and raises the per-channel end of transfer
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "hyper_defs.svh"

module hyper_trans_ctrl
   import hyper_pkg::*;
(
   input  logic                     sys_clk_i,
   input  logic                     rst_n_i,
   input  logic                     q_valid_i,
   input  hyper_cmd_t               q_cmd_i,
   output logic                     q_ready_o,
   output logic                     trans_valid_o,
   output logic [`HYPER_ADDR_W-1:0] trans_addr_o,
   output logic                     trans_write_o,
   output logic [`HYPER_LEN_W:0]    trans_burst_o,
   input  logic                     trans_ready_i,
   output logic                     tx_en_o,
   output logic                     rx_en_o,
   input  logic                     tx_beat_i,
   input  logic                     rx_beat_i,
   output logic [`HYPER_NB_CH-1:0]  evt_eot_o
);

   typedef enum logic [1:0] {st_idle, st_req, st_data, st_end} state_t;

   state_t                state_q;
   hyper_cmd_t            cmd_q;
   logic [`HYPER_LEN_W:0] beat_cnt_q;
   logic                  beat;

   assign q_ready_o     = (state_q == st_idle);
   assign trans_valid_o = (state_q == st_req);
   assign trans_addr_o  = cmd_q.addr;
   assign trans_write_o = cmd_q.write;
   // Burst in 16-bit beats
   assign trans_burst_o = {cmd_q.len, 1'b0};

   assign tx_en_o = (state_q == st_data) & cmd_q.write;
   assign rx_en_o = (state_q == st_data) & ~cmd_q.write;
   assign beat    = cmd_q.write ? tx_beat_i : rx_beat_i;

   always_comb
   begin
      evt_eot_o = '0;
      if (state_q == st_end)
         evt_eot_o[cmd_q.ch] = 1'b1;
   end

   always_ff @(posedge sys_clk_i)
   begin
      if (q_valid_i && q_ready_o)
         cmd_q <= q_cmd_i;
   end

   always_ff @(posedge sys_clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         state_q    <= st_idle;
         beat_cnt_q <= '0;
      end
      else
      begin
         case (state_q)
            st_idle:
               if (q_valid_i)
               begin
                  state_q    <= st_req;
                  beat_cnt_q <= {q_cmd_i.len, 1'b0};
               end
            st_req:
               if (trans_ready_i)
                  state_q <= st_data;
            st_data:
               if (beat)
               begin
                  beat_cnt_q <= beat_cnt_q - 1'b1;
                  if (beat_cnt_q == 'd1)
                     state_q <= st_end;
               end
            default:
               state_q <= st_idle;
         endcase
      end
   end

endmodule

// File: hyper_tx_splitter.sv
////////////////////////////////////////////////////////////////////////////
// Write path, 32-bit uDMA words to 16-bit PHY beats
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module hyper_tx_splitter
   import hyper_pkg::*;
(
   input  logic  sys_clk_i,
   input  logic  rst_n_i,
   input  logic  tx_en_i,
   input  word_t data_tx_i,
   input  logic  data_tx_valid_i,
   output logic  data_tx_ready_o,
   output logic  tx_valid_o,
   output beat_t tx_data_o,
   input  logic  tx_ready_i,
   output logic  tx_beat_o
);

   word_t word_q;
   logic  full_q;
   logic  half_q;

   assign data_tx_ready_o = tx_en_i & ~full_q;
   assign tx_valid_o      = tx_en_i & full_q;
   // Low half goes out first
   assign tx_data_o       = half_q ? word_q[31:16] : word_q[15:0];
   assign tx_beat_o       = tx_valid_o & tx_ready_i;

   always_ff @(posedge sys_clk_i)
   begin
      if (data_tx_valid_i && data_tx_ready_o)
         word_q <= data_tx_i;
   end

   always_ff @(posedge sys_clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         full_q <= 1'b0;
         half_q <= 1'b0;
      end
      else if (data_tx_valid_i && data_tx_ready_o)
      begin
         full_q <= 1'b1;
         half_q <= 1'b0;
      end
      else if (tx_beat_o)
      begin
         // Word released after its high half
         full_q <= ~half_q;
         half_q <= ~half_q;
      end
   end

endmodule

// File: hyper_rx_packer.sv
////////////////////////////////////////////////////////////////////////////
// Read path, 16-bit PHY beats to 32-bit uDMA words
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module hyper_rx_packer
   import hyper_pkg::*;
(
   input  logic  sys_clk_i,
   input  logic  rst_n_i,
   input  logic  rx_en_i,
   input  logic  rx_valid_i,
   input  beat_t rx_data_i,
   output logic  rx_ready_o,
   output logic  rx_beat_o,
   output logic  word_valid_o,
   output word_t word_o,
   input  logic  word_ready_i
);

   beat_t low_q;
   logic  half_q;

   // Stall the PHY while the read FIFO is full
   assign rx_ready_o   = rx_en_i & word_ready_i;
   assign rx_beat_o    = rx_valid_i & rx_ready_o;

   // Second beat completes the word in the same cycle
   assign word_valid_o = rx_beat_o & half_q;
   assign word_o       = {rx_data_i, low_q};

   always_ff @(posedge sys_clk_i)
   begin
      if (rx_beat_o && !half_q)
         low_q <= rx_data_i;
   end

   always_ff @(posedge sys_clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
         half_q <= 1'b0;
      else if (rx_beat_o)
         half_q <= ~half_q;
   end

endmodule

// File: udma_hyperbus.sv
////////////////////////////////////////////////////////////////////////////
// HyperBus transfer engine top, command path and both data paths
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "hyper_defs.svh"

module udma_hyperbus
   import hyper_pkg::*;
(
   input  logic                                      sys_clk_i,
   input  logic                                      rst_n_i,
   input  logic [`HYPER_NB_CH-1:0]                   cmd_valid_i,
   input  logic [`HYPER_NB_CH-1:0]                   cmd_write_i,
   input  logic [`HYPER_NB_CH-1:0][`HYPER_ADDR_W-1:0] cmd_addr_i,
   input  logic [`HYPER_NB_CH-1:0][`HYPER_LEN_W-1:0]  cmd_len_i,
   output logic [`HYPER_NB_CH-1:0]                   cmd_ready_o,
   input  word_t                                     data_tx_i,
   input  logic                                      data_tx_valid_i,
   output logic                                      data_tx_ready_o,
   output word_t                                     rx_data_udma_o,
   output logic                                      rx_valid_udma_o,
   input  logic                                      rx_ready_udma_i,
   output logic                                      trans_valid_o,
   output logic [`HYPER_ADDR_W-1:0]                  trans_addr_o,
   output logic                                      trans_write_o,
   output logic [`HYPER_LEN_W:0]                     trans_burst_o,
   input  logic                                      trans_ready_i,
   output logic                                      tx_valid_o,
   output beat_t                                     tx_data_o,
   input  logic                                      tx_ready_i,
   input  logic                                      rx_valid_i,
   input  beat_t                                     rx_data_i,
   output logic                                      rx_ready_o,
   output logic [`HYPER_NB_CH-1:0]                   evt_eot_o
);

   logic       arb_valid;
   logic       arb_ready;
   hyper_cmd_t arb_cmd;
   logic       q_valid;
   logic       q_ready;
   hyper_cmd_t q_cmd;
   logic       tx_en;
   logic       rx_en;
   logic       tx_beat;
   logic       rx_beat;
   logic       word_valid;
   logic       word_ready;
   word_t      word;

   ///////////////////////////////////////////////////////////////////////////
   // Command path
   ///////////////////////////////////////////////////////////////////////////

   hyper_cmd_arbiter arbiter_i (
      .*,
      .q_valid_o ( arb_valid ),
      .q_cmd_o   ( arb_cmd   ),
      .q_ready_i ( arb_ready )
   );

   hyper_fifo #(
      .T     ( hyper_cmd_t      ),
      .DEPTH ( `HYPER_CMD_DEPTH )
   ) cmd_fifo_i (
      .*,
      .push_valid_i ( arb_valid ),
      .push_data_i  ( arb_cmd   ),
      .push_ready_o ( arb_ready ),
      .pop_valid_o  ( q_valid   ),
      .pop_data_o   ( q_cmd     ),
      .pop_ready_i  ( q_ready   )
   );

   hyper_trans_ctrl ctrl_i (
      .*,
      .q_valid_i ( q_valid ),
      .q_cmd_i   ( q_cmd   ),
      .q_ready_o ( q_ready ),
      .tx_en_o   ( tx_en   ),
      .rx_en_o   ( rx_en   ),
      .tx_beat_i ( tx_beat ),
      .rx_beat_i ( rx_beat )
   );

   ///////////////////////////////////////////////////////////////////////////
   // Data paths
   ///////////////////////////////////////////////////////////////////////////

   hyper_tx_splitter tx_splitter_i (
      .*,
      .tx_en_i   ( tx_en   ),
      .tx_beat_o ( tx_beat )
   );

   hyper_rx_packer rx_packer_i (
      .*,
      .rx_en_i      ( rx_en      ),
      .rx_beat_o    ( rx_beat    ),
      .word_valid_o ( word_valid ),
      .word_o       ( word       ),
      .word_ready_i ( word_ready )
   );

   hyper_fifo #(
      .T     ( word_t          ),
      .DEPTH ( `HYPER_RX_DEPTH )
   ) rx_fifo_i (
      .*,
      .push_valid_i ( word_valid      ),
      .push_data_i  ( word            ),
      .push_ready_o ( word_ready      ),
      .pop_valid_o  ( rx_valid_udma_o ),
      .pop_data_o   ( rx_data_udma_o  ),
      .pop_ready_i  ( rx_ready_udma_i )
   );

endmodule

// File: tb_udma_hyperbus.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the HyperBus engine with random channels and a PHY responder
// Scoreboard for commands, write beats, read words and end of transfer
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "hyper_defs.svh"

module tb_udma_hyperbus
   import hyper_pkg::*;
();

   localparam int NB       = `HYPER_NB_CH;
   localparam int S_FREE   = 0;
   localparam int S_WAIT   = 1;
   localparam int S_QUEUED = 2;
   localparam int S_ACTIVE = 3;

   logic                                      sys_clk_i;
   logic                                      rst_n_i;
   logic [`HYPER_NB_CH-1:0]                   cmd_valid_i;
   logic [`HYPER_NB_CH-1:0]                   cmd_write_i;
   logic [`HYPER_NB_CH-1:0][`HYPER_ADDR_W-1:0] cmd_addr_i;
   logic [`HYPER_NB_CH-1:0][`HYPER_LEN_W-1:0]  cmd_len_i;
   logic [`HYPER_NB_CH-1:0]                   cmd_ready_o;
   word_t                                     data_tx_i;
   logic                                      data_tx_valid_i;
   logic                                      data_tx_ready_o;
   word_t                                     rx_data_udma_o;
   logic                                      rx_valid_udma_o;
   logic                                      rx_ready_udma_i;
   logic                                      trans_valid_o;
   logic [`HYPER_ADDR_W-1:0]                  trans_addr_o;
   logic                                      trans_write_o;
   logic [`HYPER_LEN_W:0]                     trans_burst_o;
   logic                                      trans_ready_i;
   logic                                      tx_valid_o;
   beat_t                                     tx_data_o;
   logic                                      tx_ready_i;
   logic                                      rx_valid_i;
   beat_t                                     rx_data_i;
   logic                                      rx_ready_o;
   logic [`HYPER_NB_CH-1:0]                   evt_eot_o;

   // Channel model
   int                       ch_state [NB];
   logic                     m_write [NB];
   logic [`HYPER_ADDR_W-1:0] m_addr [NB];
   logic [`HYPER_LEN_W-1:0]  m_len [NB];
   ch_id_t                   rr_ptr;

   // Transfer in progress on the PHY
   logic   cur_active;
   logic   cur_write;
   ch_id_t cur_ch;
   int     beats_left;
   logic   eot_due;

   beat_t  tx_exp [$];
   word_t  rx_exp [$];
   beat_t  rx_low;
   logic   rx_half;

   integer seed;
   logic   issue_all;
   logic   gen_en;
   logic   phy_en;
   int     xfers;
   int     trans_seen;
   int     cmds_taken;

   udma_hyperbus dut_i (.*);

   initial
   begin
      sys_clk_i = 1'b0;
      forever #2 sys_clk_i = ~sys_clk_i;
   end

   task automatic abort_run(input string what);
      $display("%s", what);
      $display("ERRORS FOUND");
      $fatal(1, "Simulation stopped");
   endtask

   task automatic compare(input string name, input logic [31:0] actual,
                          input logic [31:0] expected);
      if (actual !== expected)
         abort_run($sformatf("Mismatch %s: got %h, expected %h", name, actual, expected));
   endtask

   function automatic logic [31:0] next_rand();
      next_rand = $random(seed);
   endfunction

   function automatic logic chance(input int pct);
      logic [31:0] r;
      r = next_rand();
      return (r % 32'd100) < 32'(pct);
   endfunction

   task automatic check_idle_outputs();
      compare("trans_valid_o", 32'(trans_valid_o), 32'd0);
      compare("tx_valid_o", 32'(tx_valid_o), 32'd0);
      compare("rx_ready_o", 32'(rx_ready_o), 32'd0);
      compare("rx_valid_udma_o", 32'(rx_valid_udma_o), 32'd0);
      compare("evt_eot_o", 32'(evt_eot_o), 32'd0);
      compare("cmd_ready_o", 32'(cmd_ready_o), 32'd0);
   endtask

   ///////////////////////////////////////////////////////////////////////////
   // Scoreboard and stimulus on each rising edge
   ///////////////////////////////////////////////////////////////////////////

   always @(posedge sys_clk_i)
   begin
      logic [`HYPER_NB_CH-1:0] exp_eot;
      ch_id_t                  ch;
      logic [31:0]             r;
      if (rst_n_i)
      begin
         // End of transfer comes one cycle after the last beat
         exp_eot = '0;
         if (eot_due)
            exp_eot[cur_ch] = 1'b1;
         compare("evt_eot_o", 32'(evt_eot_o), 32'(exp_eot));
         if (eot_due)
         begin
            ch_state[cur_ch] = S_FREE;
            cur_active = 1'b0;
            eot_due = 1'b0;
            xfers++;
         end

         for (int i = 0; i < NB; i++)
         begin
            if (cmd_valid_i[i] && cmd_ready_o[i])
            begin
               // Requesters between the pointer and the grant were passed over
               for (int k = int'(rr_ptr); (k % NB) != i; k++)
                  compare("cmd_valid_i skipped", 32'(cmd_valid_i[k % NB]), 32'd0);
               rr_ptr = ch_id_t'((i + 1) % NB);
               ch_state[i] = S_QUEUED;
               cmd_valid_i[i] <= 1'b0;
               cmds_taken++;
            end
         end

         if (trans_valid_o && trans_ready_i)
         begin
            ch = trans_addr_o[`HYPER_ADDR_W-1 -: CH_W];
            compare("trans_overlap", 32'(cur_active), 32'd0);
            compare("trans_cmd_state", ch_state[ch], S_QUEUED);
            if (trans_seen < NB)
               compare("trans_rr_channel", 32'(ch), trans_seen);
            compare("trans_addr_o", trans_addr_o, m_addr[ch]);
            compare("trans_write_o", 32'(trans_write_o), 32'(m_write[ch]));
            compare("trans_burst_o", 32'(trans_burst_o), 32'(m_len[ch]) * 32'd2);
            ch_state[ch] = S_ACTIVE;
            cur_active = 1'b1;
            cur_ch = ch;
            cur_write = m_write[ch];
            beats_left = 2 * int'(m_len[ch]);
            trans_seen++;
         end

         if (data_tx_valid_i && data_tx_ready_o)
         begin
            tx_exp.push_back(data_tx_i[15:0]);
            tx_exp.push_back(data_tx_i[31:16]);
            data_tx_valid_i <= 1'b0;
         end

         if (tx_valid_o && tx_ready_i)
         begin
            compare("tx_beat_allowed", 32'(cur_active && cur_write && beats_left > 0), 32'd1);
            compare("tx_exp_level", 32'(tx_exp.size() != 0), 32'd1);
            compare("tx_data_o", 32'(tx_data_o), 32'(tx_exp.pop_front()));
            beats_left--;
            if (beats_left == 0)
               eot_due = 1'b1;
         end

         if (rx_valid_i && rx_ready_o)
         begin
            compare("rx_beat_allowed", 32'(cur_active && !cur_write && beats_left > 0), 32'd1);
            // First beat of a pair is the low half
            if (rx_half)
               rx_exp.push_back({rx_data_i, rx_low});
            else
               rx_low = rx_data_i;
            rx_half = ~rx_half;
            beats_left--;
            if (beats_left == 0)
               eot_due = 1'b1;
         end

         if (rx_valid_udma_o && rx_ready_udma_i)
         begin
            compare("rx_exp_level", 32'(rx_exp.size() != 0), 32'd1);
            compare("rx_data_udma_o", rx_data_udma_o, rx_exp.pop_front());
         end

         // New commands carry the channel number in the top address bits
         for (int i = 0; i < NB; i++)
         begin
            if (ch_state[i] == S_FREE && (issue_all || (gen_en && chance(20))))
            begin
               r = next_rand();
               m_addr[i] = {ch_id_t'(i), r[`HYPER_ADDR_W-CH_W-1:0]};
               r = next_rand();
               m_len[i] = {5'd0, r[2:0]} + 8'd1;
               m_write[i] = r[3];
               ch_state[i] = S_WAIT;
               cmd_valid_i[i] <= 1'b1;
               cmd_write_i[i] <= m_write[i];
               cmd_addr_i[i] <= m_addr[i];
               cmd_len_i[i] <= m_len[i];
            end
         end

         if (!data_tx_valid_i || data_tx_ready_o)
         begin
            if (chance(60))
            begin
               data_tx_valid_i <= 1'b1;
               data_tx_i <= next_rand();
            end
         end

         // PHY responder
         if (!rx_valid_i || rx_ready_o)
         begin
            r = next_rand();
            rx_valid_i <= phy_en && chance(50);
            rx_data_i <= r[15:0];
         end
         trans_ready_i <= phy_en && chance(50);
         tx_ready_i <= chance(70);
         rx_ready_udma_i <= chance(60);
      end
   end

   initial
   begin
      int cycles;
      int last_xfers;
      seed = 84495;
      rst_n_i = 1'b0;
      cmd_valid_i = '0;
      cmd_write_i = '0;
      cmd_addr_i = '0;
      cmd_len_i = '0;
      data_tx_i = '0;
      data_tx_valid_i = 1'b0;
      rx_ready_udma_i = 1'b0;
      trans_ready_i = 1'b0;
      tx_ready_i = 1'b0;
      rx_valid_i = 1'b0;
      rx_data_i = '0;
      for (int i = 0; i < NB; i++)
         ch_state[i] = S_FREE;
      rr_ptr = '0;
      cur_active = 1'b0;
      cur_write = 1'b0;
      cur_ch = '0;
      beats_left = 0;
      eot_due = 1'b0;
      rx_low = '0;
      rx_half = 1'b0;
      issue_all = 1'b0;
      gen_en = 1'b0;
      phy_en = 1'b0;
      xfers = 0;
      trans_seen = 0;
      cmds_taken = 0;

      repeat (2)
      begin
         @(posedge sys_clk_i);
         @(negedge sys_clk_i);
         check_idle_outputs();
      end
      @(posedge sys_clk_i);
      rst_n_i <= 1'b1;
      @(negedge sys_clk_i);
      check_idle_outputs();

      // All channels request in the same cycle while the PHY is stalled
      issue_all = 1'b1;
      @(negedge sys_clk_i);
      issue_all = 1'b0;
      cycles = 0;
      while (cmds_taken < NB)
      begin
         @(negedge sys_clk_i);
         cycles++;
         if (cycles > 50)
            abort_run("Timeout waiting for the four first commands to be accepted");
      end

      phy_en = 1'b1;
      gen_en = 1'b1;
      cycles = 0;
      last_xfers = 0;
      while (xfers < 200)
      begin
         @(negedge sys_clk_i);
         if (xfers != last_xfers)
         begin
            last_xfers = xfers;
            cycles = 0;
         end
         else
            cycles++;
         if (cycles > 2000)
            abort_run("Timeout, no end of transfer within 2000 cycles");
      end

      $display("NO ERRORS");
      $finish;
   end

endmodule

// File: sim.f
+incdir+.
hyper_pkg.sv
hyper_fifo.sv
hyper_cmd_arbiter.sv
hyper_trans_ctrl.sv
hyper_tx_splitter.sv
hyper_rx_packer.sv
udma_hyperbus.sv
tb_udma_hyperbus.sv

// File: run.sh
#!/bin/sh
# Build the HyperBus engine testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --top-module tb_udma_hyperbus -f sim.f &&
./obj_dir/Vtb_udma_hyperbus ||
exit 1
